/* Bender.yml */
package:
  name: control_unit

sources:
  - hw/controlPkg.sv
  - hw/stepCounter.sv
  - hw/instrDecoder.sv
  - hw/controlFsm.sv
  - hw/controlSignalGen.sv
  - hw/controlUnit.sv
  - target: simulation
    files:
      - test/controlUnit_assert.sv
      - test/controlUnitTb.sv

/* hw/controlFsm.sv */
module controlFsm #(
  parameter int StepWidth = 4
) (
  input  logic                    clk,
  input  logic                    reset_in,
  input  logic [StepWidth-1:0]    step,
  input  logic [StepWidth-1:0]    lastStep,
  input  controlPkg::instrClass_t instrClass,
  input  logic                    branchTaken,
  input  logic                    divisorDone,
  output controlPkg::ctrlState_t  state,
  output logic                    stepClear,
  output logic                    stepHold,
  output logic                    decodeEn
);

  controlPkg::ctrlState_t nextState;

  always_comb begin
    nextState = state;
    stepClear = 1'b0;
    stepHold  = 1'b0;
    decodeEn  = 1'b0;
    case (state)
      controlPkg::StReset: begin
        nextState = controlPkg::StFetch;
        stepClear = 1'b1;
      end
      controlPkg::StFetch: begin
        if (step == 2) begin  // Instruction register is valid
          nextState = controlPkg::StExec;
          decodeEn  = 1'b1;
          stepClear = 1'b1;
        end
      end
      controlPkg::StExec: begin
        if (step == lastStep) begin
          nextState = controlPkg::StFetch;
          stepClear = 1'b1;
        end else if (step == 2 && instrClass == controlPkg::ClsBranch && !branchTaken) begin
          nextState = controlPkg::StFetch;  // Not taken, skip PC update
          stepClear = 1'b1;
        end else if (step == 2 && instrClass == controlPkg::ClsDiv && !divisorDone) begin
          stepHold = 1'b1;  // Wait on divider
        end
      end
      default: begin
        nextState = controlPkg::StReset;
        stepClear = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= controlPkg::StReset;
    end else begin
      state <= nextState;
    end
  end

endmodule

/* hw/controlPkg.sv */
package controlPkg;

  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;
  typedef logic [3:0] aluOp_t;
  typedef logic [1:0] sel2_t;
  typedef logic [2:0] sel3_t;

  localparam aluOp_t AluPassA = 4'd0;
  localparam aluOp_t AluAdd   = 4'd1;
  localparam aluOp_t AluSub   = 4'd2;
  localparam aluOp_t AluAnd   = 4'd3;
  localparam aluOp_t AluSlt   = 4'd10;
  localparam aluOp_t AluBeq   = 4'd11;
  localparam aluOp_t AluBne   = 4'd12;
  localparam aluOp_t AluBle   = 4'd13;
  localparam aluOp_t AluBgt   = 4'd14;
  localparam aluOp_t AluLui   = 4'd15;

  localparam opcode_t OpRType = 6'h00;
  localparam opcode_t OpJ     = 6'h02;
  localparam opcode_t OpJal   = 6'h03;
  localparam opcode_t OpBeq   = 6'h04;
  localparam opcode_t OpBne   = 6'h05;
  localparam opcode_t OpBle   = 6'h06;
  localparam opcode_t OpBgt   = 6'h07;
  localparam opcode_t OpAddi  = 6'h08;
  localparam opcode_t OpAddiu = 6'h09;
  localparam opcode_t OpSlti  = 6'h0a;
  localparam opcode_t OpLui   = 6'h0f;
  localparam opcode_t OpLb    = 6'h20;
  localparam opcode_t OpLh    = 6'h21;
  localparam opcode_t OpLw    = 6'h23;
  localparam opcode_t OpSb    = 6'h28;
  localparam opcode_t OpSh    = 6'h29;
  localparam opcode_t OpSw    = 6'h2b;

  localparam funct_t FnJr  = 6'h08;
  localparam funct_t FnDiv = 6'h1a;
  localparam funct_t FnAdd = 6'h20;
  localparam funct_t FnSub = 6'h22;
  localparam funct_t FnAnd = 6'h24;
  localparam funct_t FnSlt = 6'h2a;

  // Shared by loadSize and storeSize, 0 is idle
  localparam sel2_t SizeByte = 2'd1;
  localparam sel2_t SizeHalf = 2'd2;
  localparam sel2_t SizeWord = 2'd3;

  typedef enum logic [3:0] {
    ClsAluReg, ClsAluImm, ClsLui, ClsBranch, ClsJump, ClsJal,
    ClsJr, ClsLoad, ClsStore, ClsDiv, ClsNone
  } instrClass_t;

  typedef enum logic [1:0] {
    StReset, StFetch, StExec
  } ctrlState_t;

endpackage

/* hw/controlSignalGen.sv */
module controlSignalGen #(
  parameter int StepWidth = 4
) (
  input  controlPkg::ctrlState_t  state,
  input  logic [StepWidth-1:0]    step,
  input  controlPkg::instrClass_t instrClass,
  input  controlPkg::aluOp_t      aluOp,
  input  controlPkg::sel2_t       memSize,
  output logic                    pcWrite,
  output logic                    memWrite,
  output logic                    irWrite,
  output logic                    aluOutWrite,
  output logic                    regWrite,
  output logic                    aRegWrite,
  output logic                    bRegWrite,
  output logic                    hiWrite,
  output logic                    loWrite,
  output logic                    mdrWrite,
  output controlPkg::sel2_t       pcSrc,
  output controlPkg::sel2_t       aluSrcA,
  output controlPkg::sel2_t       aluSrcB,
  output controlPkg::sel2_t       memAddrSel,
  output controlPkg::sel2_t       regDstSel,
  output controlPkg::sel3_t       regDataSel,
  output controlPkg::sel2_t       loadSize,
  output controlPkg::sel2_t       storeSize,
  output logic                    divStart,
  output logic                    divReset,
  output controlPkg::aluOp_t      aluOpOut
);

  logic inExec;

  assign inExec   = (state == controlPkg::StExec);
  assign aluOpOut = (inExec && step <= 2) ? aluOp : controlPkg::AluAdd;

  always_comb begin
    pcWrite     = 1'b0;
    memWrite    = 1'b0;
    irWrite     = 1'b0;
    aluOutWrite = 1'b0;
    regWrite    = 1'b0;
    aRegWrite   = 1'b0;
    bRegWrite   = 1'b0;
    hiWrite     = 1'b0;
    loWrite     = 1'b0;
    mdrWrite    = 1'b0;
    pcSrc       = 2'd0;
    aluSrcA     = 2'd0;
    aluSrcB     = 2'd0;
    memAddrSel  = 2'd0;
    regDstSel   = 2'd0;
    regDataSel  = 3'd0;
    loadSize    = 2'd0;
    storeSize   = 2'd0;
    divStart    = 1'b0;
    divReset    = 1'b1;

    if (state == controlPkg::StFetch) begin
      pcSrc = 2'd1;  // PC from ALUOut
      if (step == 0) begin
        irWrite     = 1'b1;
        aluOutWrite = 1'b1;
        aluSrcB     = 2'd1;  // PC + 4
      end else if (step == 2) begin
        pcWrite = 1'b1;
      end
    end else if (inExec) begin
      case (instrClass)
        controlPkg::ClsAluReg, controlPkg::ClsBranch, controlPkg::ClsStore,
        controlPkg::ClsDiv: begin
          aRegWrite = (step == 0);
          bRegWrite = (step == 0);
        end
        controlPkg::ClsAluImm, controlPkg::ClsLoad, controlPkg::ClsJr: begin
          aRegWrite = (step == 0);
        end
        default: begin
          aRegWrite = 1'b0;
        end
      endcase

      case (instrClass)
        controlPkg::ClsAluReg: begin
          aluSrcA   = 2'd1;
          regDstSel = 2'd1;  // rd
          regWrite  = (step == 2);
        end
        controlPkg::ClsAluImm: begin
          aluSrcA  = 2'd1;
          aluSrcB  = 2'd2;  // Immediate
          regWrite = (step == 2);
        end
        controlPkg::ClsLui: begin
          aluSrcB  = 2'd2;
          regWrite = (step == 2);
        end
        controlPkg::ClsBranch: begin
          if (step == 3) begin
            aluSrcB = 2'd3;  // Shifted offset
            pcWrite = 1'b1;
          end else begin
            aluSrcA = 2'd1;
          end
        end
        controlPkg::ClsJump: begin
          pcSrc   = 2'd2;
          pcWrite = (step == 0);
        end
        controlPkg::ClsJal: begin
          pcSrc      = 2'd2;
          regDstSel  = 2'd3;  // Return address register
          regDataSel = 3'd6;
          pcWrite    = (step == 0);
          regWrite   = (step == 0);
        end
        controlPkg::ClsJr: begin
          aluSrcA = 2'd1;
          pcWrite = (step == 2);
        end
        controlPkg::ClsLoad, controlPkg::ClsStore: begin
          aluSrcA     = 2'd1;
          aluSrcB     = 2'd2;
          aluOutWrite = (step == 1);
          mdrWrite    = (step == 4);
          if (step >= 2 && step <= 5) begin
            memAddrSel = 2'd1;  // Address from ALUOut
          end
          if (instrClass == controlPkg::ClsLoad) begin
            regDataSel = 3'd1;  // Memory data
            if (step == 5 || step == 6) begin
              loadSize = memSize;
            end
            regWrite = (step == 6);
          end else begin
            if (step == 5 || step == 6) begin
              storeSize = memSize;
            end
            if (step == 6) begin
              memWrite   = 1'b1;
              memAddrSel = 2'd1;
            end
          end
        end
        controlPkg::ClsDiv: begin
          divStart = (step == 1 || step == 2);
          divReset = !(step >= 1 && step <= 3);
          hiWrite  = (step == 3);
          loWrite  = (step == 3);
        end
        default: begin
          regWrite = 1'b0;  // Unknown code, no writes
        end
      endcase
    end
  end

endmodule

/* hw/controlUnit.sv */
module controlUnit #(
  parameter int StepWidth = 4
) (
  input  logic                clk,
  input  logic                reset_in,
  input  controlPkg::opcode_t opcode,
  input  controlPkg::funct_t  funct,
  input  logic                branchTaken,
  input  logic                divisorDone,
  output logic                pcWrite,
  output logic                memWrite,
  output logic                irWrite,
  output logic                aluOutWrite,
  output logic                regWrite,
  output logic                aRegWrite,
  output logic                bRegWrite,
  output logic                hiWrite,
  output logic                loWrite,
  output logic                mdrWrite,
  output controlPkg::sel2_t   pcSrc,
  output controlPkg::sel2_t   aluSrcA,
  output controlPkg::sel2_t   aluSrcB,
  output controlPkg::sel2_t   memAddrSel,
  output controlPkg::sel2_t   regDstSel,
  output controlPkg::sel3_t   regDataSel,
  output controlPkg::sel2_t   loadSize,
  output controlPkg::sel2_t   storeSize,
  output logic                divStart,
  output logic                divReset,
  output controlPkg::aluOp_t  aluOp
);

  logic                    stepClear;
  logic                    stepHold;
  logic                    decodeEn;
  logic [StepWidth-1:0]    step;
  logic [StepWidth-1:0]    lastStep;
  controlPkg::ctrlState_t  state;
  controlPkg::instrClass_t instrClass;
  controlPkg::aluOp_t      decAluOp;  // Decoded operation
  controlPkg::sel2_t       memSize;

  stepCounter #(
    .StepWidth(StepWidth)
  ) stepCounter_i (
    .clk      (clk),
    .reset_in (reset_in),
    .stepClear(stepClear),
    .stepHold (stepHold),
    .step     (step)
  );

  instrDecoder #(
    .StepWidth(StepWidth)
  ) instrDecoder_i (
    .clk       (clk),
    .reset_in  (reset_in),
    .decodeEn  (decodeEn),
    .opcode    (opcode),
    .funct     (funct),
    .instrClass(instrClass),
    .aluOp     (decAluOp),
    .memSize   (memSize),
    .lastStep  (lastStep)
  );

  controlFsm #(
    .StepWidth(StepWidth)
  ) controlFsm_i (
    .clk        (clk),
    .reset_in   (reset_in),
    .step       (step),
    .lastStep   (lastStep),
    .instrClass (instrClass),
    .branchTaken(branchTaken),
    .divisorDone(divisorDone),
    .state      (state),
    .stepClear  (stepClear),
    .stepHold   (stepHold),
    .decodeEn   (decodeEn)
  );

  controlSignalGen #(
    .StepWidth(StepWidth)
  ) controlSignalGen_i (
    .state      (state),
    .step       (step),
    .instrClass (instrClass),
    .aluOp      (decAluOp),
    .memSize    (memSize),
    .pcWrite    (pcWrite),
    .memWrite   (memWrite),
    .irWrite    (irWrite),
    .aluOutWrite(aluOutWrite),
    .regWrite   (regWrite),
    .aRegWrite  (aRegWrite),
    .bRegWrite  (bRegWrite),
    .hiWrite    (hiWrite),
    .loWrite    (loWrite),
    .mdrWrite   (mdrWrite),
    .pcSrc      (pcSrc),
    .aluSrcA    (aluSrcA),
    .aluSrcB    (aluSrcB),
    .memAddrSel (memAddrSel),
    .regDstSel  (regDstSel),
    .regDataSel (regDataSel),
    .loadSize   (loadSize),
    .storeSize  (storeSize),
    .divStart   (divStart),
    .divReset   (divReset),
    .aluOpOut   (aluOp)
  );

endmodule

/* hw/instrDecoder.sv */
module instrDecoder #(
  parameter int StepWidth = 4
) (
  input  logic                    clk,
  input  logic                    reset_in,
  input  logic                    decodeEn,
  input  controlPkg::opcode_t     opcode,
  input  controlPkg::funct_t      funct,
  output controlPkg::instrClass_t instrClass,
  output controlPkg::aluOp_t      aluOp,
  output controlPkg::sel2_t       memSize,
  output logic [StepWidth-1:0]    lastStep
);

  controlPkg::instrClass_t clsNext;
  controlPkg::aluOp_t      opNext;
  controlPkg::sel2_t       sizeNext;
  logic [StepWidth-1:0]    lastNext;

  always_comb begin
    clsNext  = controlPkg::ClsNone;
    opNext   = controlPkg::AluPassA;
    sizeNext = 2'd0;
    case (opcode)
      controlPkg::OpRType: begin
        case (funct)
          controlPkg::FnAdd: begin
            clsNext = controlPkg::ClsAluReg;
            opNext  = controlPkg::AluAdd;
          end
          controlPkg::FnAnd: begin
            clsNext = controlPkg::ClsAluReg;
            opNext  = controlPkg::AluAnd;
          end
          controlPkg::FnSub: begin
            clsNext = controlPkg::ClsAluReg;
            opNext  = controlPkg::AluSub;
          end
          controlPkg::FnSlt: begin
            clsNext = controlPkg::ClsAluReg;
            opNext  = controlPkg::AluSlt;
          end
          controlPkg::FnJr:  clsNext = controlPkg::ClsJr;   // Passes A to the PC
          controlPkg::FnDiv: clsNext = controlPkg::ClsDiv;
          default:           clsNext = controlPkg::ClsNone;
        endcase
      end
      controlPkg::OpAddi, controlPkg::OpAddiu: begin
        clsNext = controlPkg::ClsAluImm;
        opNext  = controlPkg::AluAdd;
      end
      controlPkg::OpSlti: begin
        clsNext = controlPkg::ClsAluImm;
        opNext  = controlPkg::AluSlt;
      end
      controlPkg::OpLui: begin
        clsNext = controlPkg::ClsLui;
        opNext  = controlPkg::AluLui;
      end
      controlPkg::OpBeq: begin
        clsNext = controlPkg::ClsBranch;
        opNext  = controlPkg::AluBeq;
      end
      controlPkg::OpBne: begin
        clsNext = controlPkg::ClsBranch;
        opNext  = controlPkg::AluBne;
      end
      controlPkg::OpBle: begin
        clsNext = controlPkg::ClsBranch;
        opNext  = controlPkg::AluBle;
      end
      controlPkg::OpBgt: begin
        clsNext = controlPkg::ClsBranch;
        opNext  = controlPkg::AluBgt;
      end
      controlPkg::OpLw, controlPkg::OpLh, controlPkg::OpLb: begin
        clsNext = controlPkg::ClsLoad;
        opNext  = controlPkg::AluAdd;  // Base plus offset
      end
      controlPkg::OpSw, controlPkg::OpSh, controlPkg::OpSb: begin
        clsNext = controlPkg::ClsStore;
        opNext  = controlPkg::AluAdd;
      end
      controlPkg::OpJ:   clsNext = controlPkg::ClsJump;
      controlPkg::OpJal: clsNext = controlPkg::ClsJal;
      default:           clsNext = controlPkg::ClsNone;
    endcase

    case (opcode)
      controlPkg::OpLw, controlPkg::OpSw: sizeNext = controlPkg::SizeWord;
      controlPkg::OpLh, controlPkg::OpSh: sizeNext = controlPkg::SizeHalf;
      controlPkg::OpLb, controlPkg::OpSb: sizeNext = controlPkg::SizeByte;
      default:                            sizeNext = 2'd0;
    endcase
  end

  // Final execute step per class
  always_comb begin
    case (clsNext)
      controlPkg::ClsAluReg, controlPkg::ClsAluImm, controlPkg::ClsJr,
      controlPkg::ClsBranch, controlPkg::ClsDiv:     lastNext = StepWidth'(4);
      controlPkg::ClsLui:                            lastNext = StepWidth'(3);
      controlPkg::ClsJal:                            lastNext = StepWidth'(1);
      controlPkg::ClsLoad, controlPkg::ClsStore:     lastNext = StepWidth'(8);
      default:                                       lastNext = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      instrClass <= controlPkg::ClsNone;
      aluOp      <= controlPkg::AluPassA;
      memSize    <= 2'd0;
      lastStep   <= '0;
    end else if (decodeEn) begin
      instrClass <= clsNext;
      aluOp      <= opNext;
      memSize    <= sizeNext;
      lastStep   <= lastNext;
    end
  end

endmodule

/* hw/stepCounter.sv */
module stepCounter #(
  parameter int StepWidth = 4
) (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic                 stepClear,
  input  logic                 stepHold,
  output logic [StepWidth-1:0] step
);

  always_ff @(posedge clk) begin
    if (reset_in || stepClear) begin
      step <= '0;
    end else if (!stepHold) begin
      step <= step + 1'b1;  // Next micro-step
    end
  end

endmodule

/* sim.f */
hw/controlPkg.sv
hw/stepCounter.sv
hw/instrDecoder.sv
hw/controlFsm.sv
hw/controlSignalGen.sv
hw/controlUnit.sv
test/controlUnit_assert.sv
test/controlUnitTb.sv

/* test/controlUnitTb.sv */
module controlUnitTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxRows = 32;
  localparam int Timeout = 64;

  logic                clk = 1'b0;
  logic                reset_in;
  controlPkg::opcode_t opcode;
  controlPkg::funct_t  funct;
  logic                branchTaken;
  logic                divisorDone;
  logic                pcWrite;
  logic                memWrite;
  logic                irWrite;
  logic                aluOutWrite;
  logic                regWrite;
  logic                aRegWrite;
  logic                bRegWrite;
  logic                hiWrite;
  logic                loWrite;
  logic                mdrWrite;
  controlPkg::sel2_t   pcSrc;
  controlPkg::sel2_t   aluSrcA;
  controlPkg::sel2_t   aluSrcB;
  controlPkg::sel2_t   memAddrSel;
  controlPkg::sel2_t   regDstSel;
  controlPkg::sel3_t   regDataSel;
  controlPkg::sel2_t   loadSize;
  controlPkg::sel2_t   storeSize;
  logic                divStart;
  logic                divReset;
  controlPkg::aluOp_t  aluOp;

  // Instruction table
  string               rowName      [MaxRows];
  controlPkg::opcode_t rowOpcode    [MaxRows];
  controlPkg::funct_t  rowFunct     [MaxRows];
  logic                rowTaken     [MaxRows];
  int                  rowExecLen   [MaxRows];
  controlPkg::aluOp_t  rowAluOp     [MaxRows];
  int                  rowRegWrites [MaxRows];
  int                  rowPcWrites  [MaxRows];
  controlPkg::sel2_t   rowLoadSize  [MaxRows];
  controlPkg::sel2_t   rowStoreSize [MaxRows];
  int                  rowCount = 0;
  logic [31:0]         randState = 32'h728ad330;

  always #10 clk = ~clk;

  controlUnit #(
    .StepWidth(4)
  ) controlUnit_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                        testName, what, expected, actual));
    end
  endtask

  task automatic addRow(input string name, input controlPkg::opcode_t op,
                        input controlPkg::funct_t fn, input logic taken, input int execLen,
                        input controlPkg::aluOp_t alu, input int regs, input int pcs,
                        input controlPkg::sel2_t ls, input controlPkg::sel2_t ss);
    rowName[rowCount]      = name;
    rowOpcode[rowCount]    = op;
    rowFunct[rowCount]     = fn;
    rowTaken[rowCount]     = taken;
    rowExecLen[rowCount]   = execLen;
    rowAluOp[rowCount]     = alu;
    rowRegWrites[rowCount] = regs;
    rowPcWrites[rowCount]  = pcs;
    rowLoadSize[rowCount]  = ls;
    rowStoreSize[rowCount] = ss;
    rowCount++;
  endtask

  // Starts at the negedge of an irWrite cycle, ends at the next one
  task automatic runRow(input int r);
    int                 cycle;
    int                 regCount;
    int                 pcCount;
    int                 memCount;
    int                 hiCount;
    int                 loCount;
    int                 divDelay;
    int                 doneCycle;
    int                 expLoad;
    int                 expStore;
    logic               isDiv;
    logic               isMem;
    logic               periodDone;
    controlPkg::aluOp_t opAtStep1;
    isDiv = (rowOpcode[r] == controlPkg::OpRType) && (rowFunct[r] == controlPkg::FnDiv);
    isMem = (rowLoadSize[r] != 0) || (rowStoreSize[r] != 0);
    opcode      = rowOpcode[r];
    funct       = rowFunct[r];
    branchTaken = rowTaken[r];
    divisorDone = 1'b0;
    divDelay    = 0;
    if (isDiv) begin
      randState = xorshift32(randState);
      divDelay  = int'(randState[2:0]);
    end
    cycle      = 0;
    regCount   = 0;
    pcCount    = 0;
    memCount   = 0;
    hiCount    = 0;
    loCount    = 0;
    doneCycle  = -1;
    opAtStep1  = '0;
    periodDone = 1'b0;
    while (!periodDone) begin
      regCount += regWrite;
      pcCount  += pcWrite;
      memCount += memWrite;
      hiCount  += hiWrite;
      loCount  += loWrite;
      if (hiWrite) begin
        checkValue(rowName[r], "divisorDone at hiWrite", 1, divisorDone);
      end
      expLoad  = (cycle == 8 || cycle == 9) ? rowLoadSize[r] : 0;   // Exec steps 5 and 6
      expStore = (cycle == 8 || cycle == 9) ? rowStoreSize[r] : 0;
      checkValue(rowName[r], $sformatf("loadSize cycle %0d", cycle), expLoad, loadSize);
      checkValue(rowName[r], $sformatf("storeSize cycle %0d", cycle), expStore, storeSize);
      if (cycle == 0) begin  // Fetch step 0
        checkValue(rowName[r], "aluOutWrite at fetch", 1, aluOutWrite);
        checkValue(rowName[r], "aluSrcB at fetch", 1, aluSrcB);
        checkValue(rowName[r], "pcSrc at fetch", 1, pcSrc);
        checkValue(rowName[r], "aluOp at fetch", controlPkg::AluAdd, aluOp);
      end
      if (cycle != 3) begin
        checkValue(rowName[r], $sformatf("operand writes cycle %0d", cycle), 0,
                   {aRegWrite, bRegWrite});
      end
      checkValue(rowName[r], $sformatf("mdrWrite cycle %0d", cycle),
                 isMem && cycle == 7, mdrWrite);
      if (isMem && cycle >= 5 && cycle <= 8) begin  // Exec steps 2 to 5
        checkValue(rowName[r], $sformatf("memAddrSel cycle %0d", cycle), 1, memAddrSel);
      end
      if (isDiv && divStart && doneCycle < 0) begin
        doneCycle = cycle + divDelay + 1;  // D low cycles in step 2
      end
      if (cycle == doneCycle) begin
        divisorDone = 1'b1;
      end
      @(negedge clk);
      cycle++;
      if (cycle == 4) begin
        opAtStep1 = aluOp;
      end
      if (irWrite) begin
        periodDone = 1'b1;
      end else if (cycle > Timeout) begin
        failRun($sformatf("Timeout: %s never returned to fetch", rowName[r]));
      end
    end
    if (isDiv && doneCycle < 0) begin
      failRun($sformatf("%s never raised divStart", rowName[r]));
    end
    checkValue(rowName[r], "period", 3 + rowExecLen[r] + divDelay, cycle);
    checkValue(rowName[r], "aluOp at exec step 1", rowAluOp[r], opAtStep1);
    checkValue(rowName[r], "regWrite pulses", rowRegWrites[r], regCount);
    checkValue(rowName[r], "pcWrite pulses", 1 + rowPcWrites[r], pcCount);
    checkValue(rowName[r], "memWrite pulses", (rowStoreSize[r] != 0) ? 1 : 0, memCount);
    checkValue(rowName[r], "hiWrite pulses", isDiv, hiCount);
    checkValue(rowName[r], "loWrite pulses", isDiv, loCount);
  endtask

  initial begin
    int relCycles;
    reset_in    = 1'b1;
    opcode      = '0;
    funct       = '0;
    branchTaken = 1'b0;
    divisorDone = 1'b0;

    addRow("add", controlPkg::OpRType, controlPkg::FnAdd, 0, 5, controlPkg::AluAdd, 1, 0, 0, 0);
    addRow("and", controlPkg::OpRType, controlPkg::FnAnd, 0, 5, controlPkg::AluAnd, 1, 0, 0, 0);
    addRow("sub", controlPkg::OpRType, controlPkg::FnSub, 0, 5, controlPkg::AluSub, 1, 0, 0, 0);
    addRow("slt", controlPkg::OpRType, controlPkg::FnSlt, 0, 5, controlPkg::AluSlt, 1, 0, 0, 0);
    addRow("addi", controlPkg::OpAddi, '0, 0, 5, controlPkg::AluAdd, 1, 0, 0, 0);
    addRow("addiu", controlPkg::OpAddiu, '0, 0, 5, controlPkg::AluAdd, 1, 0, 0, 0);
    addRow("slti", controlPkg::OpSlti, '0, 0, 5, controlPkg::AluSlt, 1, 0, 0, 0);
    addRow("lui", controlPkg::OpLui, '0, 0, 4, controlPkg::AluLui, 1, 0, 0, 0);
    addRow("j", controlPkg::OpJ, '0, 0, 1, controlPkg::AluAdd, 0, 1, 0, 0);  // Next fetch
    addRow("jal", controlPkg::OpJal, '0, 0, 2, controlPkg::AluPassA, 1, 1, 0, 0);
    addRow("jr", controlPkg::OpRType, controlPkg::FnJr, 0, 5, controlPkg::AluPassA, 0, 1, 0, 0);
    addRow("beq not taken", controlPkg::OpBeq, '0, 0, 3, controlPkg::AluBeq, 0, 0, 0, 0);
    addRow("beq taken", controlPkg::OpBeq, '0, 1, 5, controlPkg::AluBeq, 0, 1, 0, 0);
    addRow("bne not taken", controlPkg::OpBne, '0, 0, 3, controlPkg::AluBne, 0, 0, 0, 0);
    addRow("bne taken", controlPkg::OpBne, '0, 1, 5, controlPkg::AluBne, 0, 1, 0, 0);
    addRow("ble not taken", controlPkg::OpBle, '0, 0, 3, controlPkg::AluBle, 0, 0, 0, 0);
    addRow("ble taken", controlPkg::OpBle, '0, 1, 5, controlPkg::AluBle, 0, 1, 0, 0);
    addRow("bgt not taken", controlPkg::OpBgt, '0, 0, 3, controlPkg::AluBgt, 0, 0, 0, 0);
    addRow("bgt taken", controlPkg::OpBgt, '0, 1, 5, controlPkg::AluBgt, 0, 1, 0, 0);
    addRow("lw", controlPkg::OpLw, '0, 0, 9, controlPkg::AluAdd, 1, 0, controlPkg::SizeWord, 0);
    addRow("lh", controlPkg::OpLh, '0, 0, 9, controlPkg::AluAdd, 1, 0, controlPkg::SizeHalf, 0);
    addRow("lb", controlPkg::OpLb, '0, 0, 9, controlPkg::AluAdd, 1, 0, controlPkg::SizeByte, 0);
    addRow("sw", controlPkg::OpSw, '0, 0, 9, controlPkg::AluAdd, 0, 0, 0, controlPkg::SizeWord);
    addRow("sh", controlPkg::OpSh, '0, 0, 9, controlPkg::AluAdd, 0, 0, 0, controlPkg::SizeHalf);
    addRow("sb", controlPkg::OpSb, '0, 0, 9, controlPkg::AluAdd, 0, 0, 0, controlPkg::SizeByte);
    addRow("bad opcode", 6'h3f, '0, 0, 1, controlPkg::AluAdd, 0, 0, 0, 0);
    addRow("bad funct", controlPkg::OpRType, 6'h3f, 0, 1, controlPkg::AluAdd, 0, 0, 0, 0);
    addRow("div first", controlPkg::OpRType, controlPkg::FnDiv, 0, 5,
           controlPkg::AluPassA, 0, 0, 0, 0);
    addRow("div second", controlPkg::OpRType, controlPkg::FnDiv, 0, 5,
           controlPkg::AluPassA, 0, 0, 0, 0);

    repeat (16) begin
      @(negedge clk);
      checkValue("reset", "strobes", 0, {pcWrite, memWrite, irWrite, aluOutWrite, regWrite,
                                         aRegWrite, bRegWrite, hiWrite, loWrite, mdrWrite,
                                         divStart});
      checkValue("reset", "divReset", 1, divReset);
      checkValue("reset", "selects", 0, {pcSrc, aluSrcA, aluSrcB, memAddrSel, regDstSel,
                                         regDataSel, loadSize, storeSize});
      checkValue("reset", "aluOp", controlPkg::AluAdd, aluOp);
    end
    reset_in  = 1'b0;
    relCycles = 1;  // This cycle is still StReset
    @(negedge clk);
    relCycles++;
    while (!irWrite) begin
      if (relCycles > Timeout) begin
        failRun("Timeout: no instruction fetch after reset");
      end
      @(negedge clk);
      relCycles++;
    end
    checkValue("reset", "cycles to first irWrite", 2, relCycles);

    for (int r = 0; r < rowCount; r++) begin
      runRow(r);
    end

    if (controlUnit_i.assertChecks_i.failCount == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      failRun($sformatf("Bound assertions failed %0d times",
                        controlUnit_i.assertChecks_i.failCount));
    end
  end

endmodule

/* test/controlUnit_assert.sv */
module controlUnit_assert (
  input logic clk,
  input logic reset_in,
  input logic irWrite,
  input logic memWrite,
  input logic regWrite,
  input logic hiWrite,
  input logic loWrite
);
  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;  // Read by the testbench at the end

  irWriteSingle: assert property (@(posedge clk) disable iff (reset_in) irWrite |=> !irWrite)
    else begin
      failCount++;
      $error("irWrite high in two consecutive cycles");
    end

  memRegExclusive: assert property (@(posedge clk) disable iff (reset_in)
    !(memWrite && regWrite))
    else begin
      failCount++;
      $error("memWrite and regWrite high together");
    end

  hiWithLo: assert property (@(posedge clk) disable iff (reset_in) hiWrite |-> loWrite)
    else begin
      failCount++;
      $error("hiWrite high without loWrite");
    end

endmodule

bind controlUnit controlUnit_assert assertChecks_i (
  .clk     (clk),
  .reset_in(reset_in),
  .irWrite (irWrite),
  .memWrite(memWrite),
  .regWrite(regWrite),
  .hiWrite (hiWrite),
  .loWrite (loWrite)
);
